// File: Bender.yml
package:
  name: rv_decoder

sources:
  - include_dirs:
      - source
    files:
      - source/rv_decode_pkg.sv
      - source/imm_gen.sv
      - source/op_decode.sv
      - source/decode_issue.sv
      - source/rv_decoder.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_rv_decoder.sv

// File: dv/decode_stimulus.txt
# inst rd rs1 rs2 imm alu_op branch_op ls_size (hex, enum codes)
# is_unsigned is_word is_imm is_load is_store need_to_wb
123452b7 05 08 03 0000000012345000 a 0 0 0 0 0 0 0 1
fffff0b7 01 1f 1f fffffffffffff000 a 0 0 0 0 0 0 0 1
80000517 0a 00 00 ffffffff80000000 b 0 0 0 0 0 0 0 1
001000ef 01 00 01 0000000000000800 0 1 0 0 0 0 0 0 1
ffdff06f 00 1f 1d fffffffffffffffc 0 1 0 0 0 0 0 0 1
010280e7 01 05 10 0000000000000010 0 2 0 0 0 0 0 0 1
00208463 08 01 02 0000000000000008 0 3 0 0 0 0 0 0 0
fe4198e3 11 03 04 fffffffffffffff0 0 4 0 0 0 0 0 0 0
0062c0e3 01 05 06 0000000000000800 0 5 0 0 0 0 0 0 0
0083d263 04 07 08 0000000000000004 0 6 0 0 0 0 0 0 0
8020e063 00 01 02 fffffffffffff000 0 5 0 1 0 0 0 0 0
00a4f663 0c 09 0a 000000000000000c 0 6 0 1 0 0 0 0 0
fff10083 01 02 1f ffffffffffffffff 0 0 1 0 0 0 1 0 1
00221183 03 04 02 0000000000000002 0 0 2 0 0 0 1 0 1
00432283 05 06 04 0000000000000004 0 0 3 0 0 0 1 0 1
00843383 07 08 08 0000000000000008 0 0 4 0 0 0 1 0 1
7ff54483 09 0a 1f 00000000000007ff 0 0 1 1 0 0 1 0 1
00065583 0b 0c 00 0000000000000000 0 0 2 1 0 0 1 0 1
80076683 0d 0e 00 fffffffffffff800 0 0 3 1 0 0 1 0 1
002082a3 05 01 02 0000000000000005 0 0 1 0 0 0 0 1 0
fe321f23 1e 04 03 fffffffffffffffe 0 0 2 0 0 0 0 1 0
04532023 00 06 05 0000000000000040 0 0 3 0 0 0 0 1 0
00743823 10 08 07 0000000000000010 0 0 4 0 0 0 0 1 0
ffb10093 01 02 1b fffffffffffffffb 1 0 0 0 0 1 0 0 1
00123193 03 04 01 0000000000000001 4 0 0 1 0 1 0 0 1
42835293 05 06 08 0000000000000428 7 0 0 0 0 1 0 0 1
403100b3 01 02 03 0000000000000000 2 0 0 0 0 0 0 0 1
0062b233 04 05 06 0000000000000000 4 0 0 1 0 0 0 0 1
4052519b 03 04 05 0000000000000405 7 0 0 0 1 1 0 0 1
407302bb 05 06 07 0000000000000000 2 0 0 0 1 0 0 0 1
0ff0000f 00 00 1f 0000000000000000 0 0 0 0 0 0 0 0 0
00000073 00 00 00 0000000000000000 0 0 0 0 0 0 0 0 0
023100b3 01 02 03 0000000000000000 0 0 0 0 0 0 0 0 0
0262c23b 04 05 06 0000000000000000 0 0 0 0 0 0 0 0 0

// File: dv/tb_rv_decoder.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module tb_rv_decoder;

    logic                       clock;
    logic                       rst;
    logic                       inst_valid;
    logic [`RV_ILEN-1:0]        inst;
    logic                       inst_ready;
    logic                       uop_valid;
    rv_decode_pkg::decode_uop_t uop;
    logic                       credit_return;

    logic [`RV_ILEN-1:0]        words[$];
    rv_decode_pkg::decode_uop_t expected[$];
    rv_decode_pkg::decode_uop_t exp_q[$];      // Accepted but not yet issued
    logic                       accepted_last;
    int                         model_credits;
    int                         held;          // Micro-ops sitting in execute
    logic                       hold_credits;
    logic [31:0]                lfsr;

    rv_decoder UUT (
        .clock         (clock),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_ready    (inst_ready),
        .uop_valid     (uop_valid),
        .uop           (uop),
        .credit_return (credit_return)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ************************************************************************
    // Checks
    // ************************************************************************
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_imm(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: uop.imm is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_ctrl(input rv_decode_pkg::decode_uop_t got,
                              input rv_decode_pkg::decode_uop_t exp);
        rv_decode_pkg::decode_uop_t g;
        rv_decode_pkg::decode_uop_t e;
        g     = got;
        e     = exp;
        g.imm = '0;    // Immediate has its own check
        e.imm = '0;
        if (g !== e) begin
            abort_run($sformatf("Error at %0t ns: uop control is %h, expected %h", $time, g, e));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic load_stimulus();
        int                         fd;
        int                         n;
        logic [8*200-1:0]           line;
        logic [63:0]                v[14];
        rv_decode_pkg::decode_uop_t e;
        fd = $fopen("dv/decode_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file dv/decode_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = '0;
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
                           v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                           v[12], v[13]);
            if (n == 14) begin
                words.push_back(v[0][`RV_ILEN-1:0]);
                e.rd          = v[1][`RV_REG_IDX_W-1:0];
                e.rs1         = v[2][`RV_REG_IDX_W-1:0];
                e.rs2         = v[3][`RV_REG_IDX_W-1:0];
                e.imm         = v[4];
                e.alu_op      = rv_decode_pkg::alu_op_e'(v[5][3:0]);
                e.branch_op   = rv_decode_pkg::branch_op_e'(v[6][2:0]);
                e.ls_size     = rv_decode_pkg::ls_size_e'(v[7][2:0]);
                e.is_unsigned = v[8][0];
                e.is_word     = v[9][0];
                e.is_imm      = v[10][0];
                e.is_load     = v[11][0];
                e.is_store    = v[12][0];
                e.need_to_wb  = v[13][0];
                expected.push_back(e);
            end else if (n > 0) begin
                abort_run("The stimulus file has a line with missing columns");
            end
        end
        $fclose(fd);
        if (words.size() <= `DEC_CREDITS) begin
            abort_run("The stimulus file holds too few instructions");
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after acceptance
    task automatic send_inst(input int idx);
        int waited;
        inst_valid = 1'b1;
        inst       = words[idx];
        waited     = 0;
        while (!inst_ready) begin
            @(negedge clock);
            waited++;
            if (waited > 50) begin
                abort_run("Timeout: inst_ready stayed low while an instruction waited");
            end
        end
        exp_q.push_back(expected[idx]);
        @(negedge clock);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || held != 0) begin
            @(negedge clock);
            waited++;
            if (waited > 200) begin
                abort_run("Timeout: accepted micro-ops or credits never came back");
            end
        end
    endtask

    // ************************************************************************
    // Reference model and monitor
    // ************************************************************************
    always @(posedge clock) begin
        if (rst) begin
            model_credits <= `DEC_CREDITS;
            accepted_last <= 1'b0;
        end else begin
            accepted_last <= inst_valid && inst_ready;
            model_credits <= model_credits - int'(inst_valid && inst_ready) + int'(credit_return);
        end
    end

    always @(negedge clock) begin
        if (!rst) begin
            check_bit("inst_ready", inst_ready, model_credits != 0);
            check_bit("uop_valid", uop_valid, accepted_last);   // One cycle after accept
            if (uop_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("A micro-op came out with no accepted instruction behind it");
                end
                check_ctrl(uop, exp_q[0]);
                check_imm(uop.imm, exp_q[0].imm);
                void'(exp_q.pop_front());
                held++;
            end
        end
    end

    // Execute side frees one slot per pulse after a random delay
    initial begin : execute_model
        int delay;
        credit_return = 1'b0;
        lfsr          = 32'h4772;
        forever begin
            @(negedge clock);
            if (!rst && !hold_credits && held > 0) begin
                delay = 0;
                repeat (3) begin
                    lfsr  = lfsr_next(lfsr);
                    delay = (delay << 1) | int'(lfsr[0]);
                end
                repeat (delay) @(negedge clock);
                credit_return = 1'b1;
                held--;
                @(negedge clock);
                credit_return = 1'b0;
            end
        end
    end

    initial begin
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        hold_credits = 1'b1;
        held         = 0;
        load_stimulus();
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        check_bit("uop_valid", uop_valid, 1'b0);
        check_bit("inst_ready", inst_ready, 1'b1);

        // Fill every credit while execute holds on to them
        for (int i = 0; i < `DEC_CREDITS; i++) begin
            send_inst(i);
        end
        inst_valid = 1'b1;
        inst       = words[`DEC_CREDITS];
        repeat (8) begin
            @(negedge clock);
            check_bit("inst_ready", inst_ready, 1'b0);
        end
        hold_credits = 1'b0;

        for (int i = `DEC_CREDITS; i < words.size(); i++) begin
            send_inst(i);
        end
        inst_valid = 1'b0;
        wait_drain();
        @(negedge clock);
        check_bit("inst_ready", inst_ready, 1'b1);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: source/decode_issue.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module decode_issue (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       inst_valid,
    output logic                       inst_ready,
    input  rv_decode_pkg::decode_uop_t ctrl,
    input  rv_decode_pkg::imm_fmt_e    imm_fmt,
    input  rv_decode_pkg::imm_set_t    imms,
    output logic                       uop_valid,
    output rv_decode_pkg::decode_uop_t uop,
    input  logic                       credit_return
);

    localparam logic [`DEC_CREDIT_W-1:0] CREDIT_MAX = `DEC_CREDITS;

    logic [`DEC_CREDIT_W-1:0]   credits;
    logic                       accept;
    rv_decode_pkg::decode_uop_t merged;

    assign inst_ready = (credits != '0);
    assign accept     = inst_valid && inst_ready;

    always_comb begin
        merged = ctrl;
        case (imm_fmt)
            rv_decode_pkg::IMM_I: merged.imm = imms.i_imm;
            rv_decode_pkg::IMM_S: merged.imm = imms.s_imm;
            rv_decode_pkg::IMM_B: merged.imm = imms.b_imm;
            rv_decode_pkg::IMM_U: merged.imm = imms.u_imm;
            rv_decode_pkg::IMM_J: merged.imm = imms.j_imm;
            default: merged.imm = '0;
        endcase
    end

    // Spend on accept, refill on return, both cancel
    always_ff @(posedge clock) begin
        if (rst) begin
            credits   <= CREDIT_MAX;
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= accept;
            if (accept && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (!accept && credit_return) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            uop <= merged;
        end
    end

    credit_bound: assert property (@(posedge clock) disable iff (rst)
        credits <= CREDIT_MAX);

    // Execute cannot free a slot nothing occupies
    no_return_when_full: assert property (@(posedge clock) disable iff (rst)
        credits == CREDIT_MAX |-> !credit_return);

endmodule

// File: source/imm_gen.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module imm_gen (
    input  logic [`RV_ILEN-1:0]    inst,
    output rv_decode_pkg::imm_set_t imms
);

    logic [11:0] raw_i;
    logic [11:0] raw_s;
    logic [12:0] raw_b;
    logic [31:0] raw_u;
    logic [20:0] raw_j;

    // ************************************************************************
    // Raw fields per format
    // ************************************************************************
    assign raw_i = inst[31:20];
    assign raw_s = {inst[31:25], inst[11:7]};

    // Branch offset is scattered, bit 0 implied zero
    assign raw_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign raw_u = {inst[31:12], 12'b0};   // Upper 20 bits

    assign raw_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // ************************************************************************
    // Sign extension to XLEN
    // ************************************************************************
    assign imms.i_imm = {{(`RV_XLEN-12){raw_i[11]}}, raw_i};
    assign imms.s_imm = {{(`RV_XLEN-12){raw_s[11]}}, raw_s};
    assign imms.b_imm = {{(`RV_XLEN-13){raw_b[12]}}, raw_b};
    assign imms.u_imm = {{(`RV_XLEN-32){raw_u[31]}}, raw_u};
    assign imms.j_imm = {{(`RV_XLEN-21){raw_j[20]}}, raw_j};

endmodule

// File: source/op_decode.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module op_decode (
    input  logic [`RV_ILEN-1:0]       inst,
    output rv_decode_pkg::decode_uop_t ctrl,
    output rv_decode_pkg::imm_fmt_e    imm_fmt
);

    rv_decode_pkg::opcode_e    opcode;
    rv_decode_pkg::decode_uop_t dec;
    rv_decode_pkg::imm_fmt_e    fmt;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic                      hit;    // Encoding matched a supported row

    assign opcode = rv_decode_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        dec     = '0;
        dec.rd  = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        fmt     = rv_decode_pkg::IMM_NONE;
        hit     = 1'b1;

        case (opcode)
            rv_decode_pkg::OP_LUI: begin
                dec.alu_op     = rv_decode_pkg::ALU_LUI;
                dec.need_to_wb = 1'b1;
                fmt            = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OP_AUIPC: begin
                dec.alu_op     = rv_decode_pkg::ALU_AUIPC;
                dec.need_to_wb = 1'b1;
                fmt            = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OP_JAL: begin
                dec.branch_op  = rv_decode_pkg::BR_JAL;
                dec.need_to_wb = 1'b1;
                fmt            = rv_decode_pkg::IMM_J;
            end
            rv_decode_pkg::OP_JALR: begin
                dec.branch_op  = rv_decode_pkg::BR_JALR;
                dec.need_to_wb = 1'b1;
                fmt            = rv_decode_pkg::IMM_I;
                hit            = (funct3 == 3'b000);
            end

            // ****************************************************************
            // Control transfer and memory
            // ****************************************************************
            rv_decode_pkg::OP_BRANCH: begin
                fmt             = rv_decode_pkg::IMM_B;
                dec.is_unsigned = funct3[1];   // BLTU, BGEU
                case (funct3)
                    3'b000: dec.branch_op = rv_decode_pkg::BR_BEQ;
                    3'b001: dec.branch_op = rv_decode_pkg::BR_BNE;
                    3'b100, 3'b110: dec.branch_op = rv_decode_pkg::BR_BLT;
                    3'b101, 3'b111: dec.branch_op = rv_decode_pkg::BR_BGE;
                    default: hit = 1'b0;
                endcase
            end
            rv_decode_pkg::OP_LOAD: begin
                dec.is_load     = 1'b1;
                dec.need_to_wb  = 1'b1;
                dec.is_unsigned = funct3[2];   // LBU, LHU, LWU
                fmt             = rv_decode_pkg::IMM_I;
                case (funct3)
                    3'b000, 3'b100: dec.ls_size = rv_decode_pkg::LS_B;
                    3'b001, 3'b101: dec.ls_size = rv_decode_pkg::LS_H;
                    3'b010, 3'b110: dec.ls_size = rv_decode_pkg::LS_W;
                    3'b011: dec.ls_size = rv_decode_pkg::LS_D;
                    default: hit = 1'b0;
                endcase
            end
            rv_decode_pkg::OP_STORE: begin
                dec.is_store = 1'b1;
                fmt          = rv_decode_pkg::IMM_S;
                case (funct3)
                    3'b000: dec.ls_size = rv_decode_pkg::LS_B;
                    3'b001: dec.ls_size = rv_decode_pkg::LS_H;
                    3'b010: dec.ls_size = rv_decode_pkg::LS_W;
                    3'b011: dec.ls_size = rv_decode_pkg::LS_D;
                    default: hit = 1'b0;
                endcase
            end

            // ****************************************************************
            // Integer ALU
            // ****************************************************************
            rv_decode_pkg::OP_IMM: begin
                dec.is_imm      = 1'b1;
                dec.need_to_wb  = 1'b1;
                dec.is_unsigned = (funct3 == 3'b011);  // SLTIU
                fmt             = rv_decode_pkg::IMM_I;
                case (funct3)
                    3'b000: dec.alu_op = rv_decode_pkg::ALU_ADD;
                    3'b010, 3'b011: dec.alu_op = rv_decode_pkg::ALU_SLT;
                    3'b100: dec.alu_op = rv_decode_pkg::ALU_XOR;
                    3'b110: dec.alu_op = rv_decode_pkg::ALU_OR;
                    3'b111: dec.alu_op = rv_decode_pkg::ALU_AND;
                    3'b001: begin
                        dec.alu_op = rv_decode_pkg::ALU_SLL;
                        hit        = (inst[31:26] == 6'b000000);  // 6-bit shamt on full width
                    end
                    default: begin
                        dec.alu_op = inst[30] ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
                        hit        = ({inst[31], inst[29:26]} == 5'b00000);
                    end
                endcase
            end
            rv_decode_pkg::OP_IMM_32: begin
                dec.is_imm     = 1'b1;
                dec.is_word    = 1'b1;
                dec.need_to_wb = 1'b1;
                fmt            = rv_decode_pkg::IMM_I;
                casez ({funct7, funct3})
                    10'b???????_000: dec.alu_op = rv_decode_pkg::ALU_ADD;
                    10'b0000000_001: dec.alu_op = rv_decode_pkg::ALU_SLL;
                    10'b0000000_101: dec.alu_op = rv_decode_pkg::ALU_SRL;
                    10'b0100000_101: dec.alu_op = rv_decode_pkg::ALU_SRA;
                    default: hit = 1'b0;
                endcase
            end
            rv_decode_pkg::OP_OP: begin
                dec.need_to_wb  = 1'b1;
                dec.is_unsigned = (funct3 == 3'b011);  // SLTU
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rv_decode_pkg::ALU_ADD;
                    10'b0100000_000: dec.alu_op = rv_decode_pkg::ALU_SUB;
                    10'b0000000_001: dec.alu_op = rv_decode_pkg::ALU_SLL;
                    10'b0000000_010: dec.alu_op = rv_decode_pkg::ALU_SLT;
                    10'b0000000_011: dec.alu_op = rv_decode_pkg::ALU_SLT;
                    10'b0000000_100: dec.alu_op = rv_decode_pkg::ALU_XOR;
                    10'b0000000_101: dec.alu_op = rv_decode_pkg::ALU_SRL;
                    10'b0100000_101: dec.alu_op = rv_decode_pkg::ALU_SRA;
                    10'b0000000_110: dec.alu_op = rv_decode_pkg::ALU_OR;
                    10'b0000000_111: dec.alu_op = rv_decode_pkg::ALU_AND;
                    default: hit = 1'b0;   // Includes MUL/DIV
                endcase
            end
            rv_decode_pkg::OP_OP_32: begin
                dec.is_word    = 1'b1;
                dec.need_to_wb = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rv_decode_pkg::ALU_ADD;
                    10'b0100000_000: dec.alu_op = rv_decode_pkg::ALU_SUB;
                    10'b0000000_001: dec.alu_op = rv_decode_pkg::ALU_SLL;
                    10'b0000000_101: dec.alu_op = rv_decode_pkg::ALU_SRL;
                    10'b0100000_101: dec.alu_op = rv_decode_pkg::ALU_SRA;
                    default: hit = 1'b0;
                endcase
            end
            default: hit = 1'b0;   // FENCE, ENV and unknown
        endcase
    end

    // Misses keep only the register indices
    always_comb begin
        ctrl    = '0;
        imm_fmt = rv_decode_pkg::IMM_NONE;
        if (hit) begin
            ctrl    = dec;
            imm_fmt = fmt;
        end else begin
            ctrl.rd  = dec.rd;
            ctrl.rs1 = dec.rs1;
            ctrl.rs2 = dec.rs2;
        end
    end

    // Checked on each new instruction word
    load_store_excl: assert property (@(inst)
        !(ctrl.is_load === 1'b1 && ctrl.is_store === 1'b1));

endmodule

// File: source/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // Major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_FENCE    = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_IMM_32   = 7'b0011011,
        OP_STORE    = 7'b0100011,
        OP_OP       = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_OP_32    = 7'b0111011,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_ENV      = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Unsigned compares share BLT/BGE with is_unsigned set
    typedef enum logic [2:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE
    } branch_op_e;

    typedef enum logic [2:0] {
        LS_NONE, LS_B, LS_H, LS_W, LS_D
    } ls_size_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    // All immediate formats, already sign-extended
    typedef struct packed {
        logic [`RV_XLEN-1:0] i_imm;
        logic [`RV_XLEN-1:0] s_imm;
        logic [`RV_XLEN-1:0] b_imm;
        logic [`RV_XLEN-1:0] u_imm;
        logic [`RV_XLEN-1:0] j_imm;
    } imm_set_t;

    typedef struct packed {
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [`RV_REG_IDX_W-1:0] rs2;
        logic [`RV_XLEN-1:0]      imm;
        alu_op_e                  alu_op;
        branch_op_e               branch_op;
        ls_size_e                 ls_size;
        logic                     is_unsigned;
        logic                     is_word;
        logic                     is_imm;
        logic                     is_load;
        logic                     is_store;
        logic                     need_to_wb;
    } decode_uop_t;

endpackage

// File: source/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// ************************************************************************
// Datapath widths
// ************************************************************************
`define RV_XLEN       64    // Register and immediate width
`define RV_ILEN       32
`define RV_REG_IDX_W  5     // x0..x31

// ************************************************************************
// Flow control toward execute
// ************************************************************************
// Micro-ops that execute can hold at once
`define DEC_CREDITS   2
`define DEC_CREDIT_W  2     // Must hold DEC_CREDITS

`endif

// File: source/rv_decoder.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module rv_decoder (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       inst_valid,
    input  logic [`RV_ILEN-1:0]        inst,
    output logic                       inst_ready,
    output logic                       uop_valid,
    output rv_decode_pkg::decode_uop_t uop,
    input  logic                       credit_return
);

    rv_decode_pkg::imm_set_t    imms;
    rv_decode_pkg::decode_uop_t ctrl;
    rv_decode_pkg::imm_fmt_e    imm_fmt;

    imm_gen u_imm_gen (
        .inst (inst),
        .imms (imms)
    );

    op_decode u_op_decode (
        .inst    (inst),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    decode_issue u_decode_issue (
        .clock         (clock),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .ctrl          (ctrl),
        .imm_fmt       (imm_fmt),
        .imms          (imms),
        .uop_valid     (uop_valid),
        .uop           (uop),
        .credit_return (credit_return)
    );

endmodule

// File: vlog.f
+incdir+source
source/rv_decode_pkg.sv
source/imm_gen.sv
source/op_decode.sv
source/decode_issue.sv
source/rv_decoder.sv
dv/tb_rv_decoder.sv
